// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_video
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+verilog
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_char.sv
verilog/video_scroll.sv
verilog/video_colmix.sv
verilog/video_top.sv
testbench/video_assertions.sv
testbench/video_checker.sv
testbench/tb_video.sv

// File: testbench/tb_video.sv
// Clock, reset, pattern ROM models, test table and the video_top DUT instance
`include "video_macros.svh"

module tb_video;
timeunit 1ns;
timeprecision 100ps;
import video_pkg::*;

localparam int N_TESTS   = 6;
localparam int VS_LIMIT  = 2 * `H_TOTAL * `V_TOTAL * 4;   // Two frames of clocks

logic        clk;
logic        rst;
logic        pxl_cen = 1'b0;
logic [1:0]  cen_cnt = 2'd0;
cpu_addr_t   cpu_addr;
logic        cpu_wrn;
cpu_data_t   cpu_dout;
logic        cen_Q;
logic        char_cs;
logic        scr_cs;
logic        pal_cs;
cpu_data_t   char_dout;
cpu_data_t   scr_dout;
cpu_data_t   pal_dout;
hpos_t       scrhpos;
vpos_t       scrvpos;
gfx_addr_t   char_addr;
gfx_row_t    char_data = '0;
gfx_addr_t   scr_addr;
gfx_row_t    scr_data = '0;
logic        hbl;
logic        vbl;
logic        hs;
logic        vs;
logic        ims;
logic        lhbl_dly;
logic        lvbl_dly;
colour_t     red;
colour_t     green;
colour_t     blue;
logic        check_en;
logic [127:0] test_name;
int          err_count;
int          check_count;

// Test table
logic [127:0] t_name[N_TESTS];
bit          t_frame[N_TESTS];      // 0 write and read back, 1 frame check
bit          t_rand_scroll[N_TESTS];
hpos_t       t_scrh[N_TESTS];
vpos_t       t_scrv[N_TESTS];
int          t_frames[N_TESTS];

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// One tick in four clocks
always @(posedge clk) begin
    #1;
    cen_cnt = cen_cnt + 2'd1;
    pxl_cen = (cen_cnt == 2'd0);
end

function automatic logic [3:0] gfx_nibble(bit layer, logic [7:0] code, logic [2:0] row,
                                          logic [2:0] col);
    logic [3:0] mix;
    if (!layer) begin
        if (code[7:6] == 2'b00) begin
            return 4'h0;                // Empty char tiles
        end
        mix = code[3:0] ^ {row, 1'b0} ^ {1'b0, col};
    end else begin
        mix = code[3:0] + code[7:4] + {1'b0, row} + {col, 1'b0};
    end
    return mix;
endfunction

function automatic gfx_row_t rom_row(bit layer, gfx_addr_t addr);
    gfx_row_t row_bits;
    for (int x = 0; x < 8; x++) begin
        row_bits[x*4 +: 4] = gfx_nibble(layer, addr[10:3], addr[2:0], 3'(x));
    end
    return row_bits;
endfunction

// Pattern ROMs with one clock of latency
always @(posedge clk) begin
    char_data <= rom_row(1'b0, char_addr);
    scr_data  <= rom_row(1'b1, scr_addr);
end

video_top i_dut(
    .clk (clk), .rst (rst), .pxl_cen (pxl_cen),
    .cpu_addr (cpu_addr), .cpu_wrn (cpu_wrn), .cpu_dout (cpu_dout), .cen_Q (cen_Q),
    .char_cs (char_cs), .scr_cs (scr_cs), .pal_cs (pal_cs),
    .char_dout (char_dout), .scr_dout (scr_dout), .pal_dout (pal_dout),
    .scrhpos (scrhpos), .scrvpos (scrvpos),
    .char_addr (char_addr), .char_data (char_data),
    .scr_addr (scr_addr), .scr_data (scr_data),
    .hbl (hbl), .vbl (vbl), .hs (hs), .vs (vs), .ims (ims),
    .lhbl_dly (lhbl_dly), .lvbl_dly (lvbl_dly),
    .red (red), .green (green), .blue (blue)
);

video_checker u_checker(
    .clk (clk), .rst (rst), .pxl_cen (pxl_cen),
    .cpu_addr (cpu_addr), .cpu_wrn (cpu_wrn), .cpu_dout (cpu_dout), .cen_Q (cen_Q),
    .char_cs (char_cs), .scr_cs (scr_cs), .pal_cs (pal_cs),
    .char_dout (char_dout), .scr_dout (scr_dout), .pal_dout (pal_dout),
    .scrhpos (scrhpos), .scrvpos (scrvpos),
    .hbl (hbl), .vbl (vbl), .hs (hs), .vs (vs), .ims (ims),
    .lhbl_dly (lhbl_dly), .lvbl_dly (lvbl_dly),
    .red (red), .green (green), .blue (blue),
    .check_en (check_en), .test_name (test_name),
    .err_count (err_count), .check_count (check_count)
);

task automatic finish_run(input bit ok);
    if (ok) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
endtask

task automatic timeout(input string what);
    $display("Timeout while waiting for %0s", what);
    finish_run(1'b0);
endtask

// sel 0 char map, 1 background map, 2 palette
task automatic cpu_access(input logic [1:0] sel, input cpu_addr_t addr, input cpu_data_t data,
                          input bit wr);
    cpu_addr = addr;
    cpu_dout = data;
    cpu_wrn  = !wr;
    cen_Q    = wr;
    char_cs  = (sel == 2'd0);
    scr_cs   = (sel == 2'd1);
    pal_cs   = (sel == 2'd2);
    @(posedge clk);
    #1;
    char_cs  = 1'b0;
    scr_cs   = 1'b0;
    pal_cs   = 1'b0;
    cpu_wrn  = 1'b1;
    cen_Q    = 1'b0;
endtask

task automatic wait_ticks(input int n);
    int seen;
    int guard;
    seen  = 0;
    guard = 0;
    while (seen < n) begin
        @(posedge clk);
        if (pxl_cen) seen++;
        #1;
        guard++;
        if (guard > 8 * n + 16) timeout("pixel clock enable");
    end
endtask

task automatic wait_vs_rise();
    int   guard;
    logic vs_prev;
    guard   = 0;
    vs_prev = vs;
    while (!(vs && !vs_prev)) begin
        vs_prev = vs;
        @(posedge clk);
        #1;
        guard++;
        if (guard > VS_LIMIT) timeout("vertical sync");
    end
endtask

task automatic run_readback();
    for (int s = 0; s < 3; s++) begin
        for (int i = 0; i < 64; i++) cpu_access(2'(s), {6'($urandom), 6'(i)}, 8'($urandom), 1'b1);
        for (int i = 0; i < 64; i++) cpu_access(2'(s), {6'($urandom), 6'(i)}, 8'h00, 1'b0);
    end
endtask

task automatic run_frames(input int t);
    check_en = 1'b0;
    for (int s = 0; s < 3; s++) begin
        for (int i = 0; i < 64; i++) cpu_access(2'(s), 12'(i), 8'($urandom), 1'b1);
    end
    if (t_rand_scroll[t]) begin
        scrhpos = 8'($urandom);
        scrvpos = 8'($urandom);
    end else begin
        scrhpos = t_scrh[t];
        scrvpos = t_scrv[t];
    end
    wait_ticks(4);               // Flush pixels fetched before the writes
    check_en = 1'b1;
    wait_vs_rise();
    for (int f = 0; f < t_frames[t]; f++) wait_vs_rise();
    check_en = 1'b0;
endtask

task automatic add_test(input int t, input logic [127:0] name, input bit frame,
                        input bit rand_scroll, input hpos_t sh, input vpos_t sv, input int frames);
    t_name[t]        = name;
    t_frame[t]       = frame;
    t_rand_scroll[t] = rand_scroll;
    t_scrh[t]        = sh;
    t_scrv[t]        = sv;
    t_frames[t]      = frames;
endtask

initial begin
    int err_before;
    int chk_before;
    void'($urandom(32'h2256));
    rst       = 1'b1;
    cpu_addr  = '0;
    cpu_wrn   = 1'b1;
    cpu_dout  = '0;
    cen_Q     = 1'b0;
    char_cs   = 1'b0;
    scr_cs    = 1'b0;
    pal_cs    = 1'b0;
    scrhpos   = '0;
    scrvpos   = '0;
    check_en  = 1'b0;
    test_name = "reset";
    add_test(0, "readback",     1'b0, 1'b0, 8'd0,  8'd0, 0);
    add_test(1, "raster",       1'b1, 1'b0, 8'd0,  8'd0, 1);
    add_test(2, "priority",     1'b1, 1'b0, 8'd0,  8'd0, 1);
    add_test(3, "scroll_fixed", 1'b1, 1'b0, 8'd13, 8'd5, 1);
    add_test(4, "scroll_rand",  1'b1, 1'b1, 8'd0,  8'd0, 2);
    add_test(5, "blanking",     1'b1, 1'b1, 8'd0,  8'd0, 1);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
        err_before = err_count;
        chk_before = check_count;
        test_name  = t_name[t];
        if (t_frame[t]) begin
            run_frames(t);
        end else begin
            run_readback();
        end
        wait_ticks(1);
        $display("Test %0s: %0d checks, %0d errors", t_name[t],
                 check_count - chk_before, err_count - err_before);
    end
    $display("Tests %0d, checks %0d, errors %0d", N_TESTS, check_count, err_count);
    finish_run(err_count == 0);
end

endmodule

// File: testbench/video_assertions.sv
// Sync and blanking properties bound to the raster timing generator
`include "video_macros.svh"

module video_assertions(
    input                     clk,
    input                     rst,
    input  video_pkg::hpos_t  hpos,
    input  video_pkg::vpos_t  vpos,
    input                     hbl,
    input                     vbl,
    input                     hs,
    input                     vs
);
timeunit 1ns;
timeprecision 100ps;

hs_in_hblank: assert property (@(posedge clk) disable iff (rst) hs |-> hbl)
    else $error("hs active outside horizontal blanking");

vs_in_vblank: assert property (@(posedge clk) disable iff (rst) vs |-> vbl)
    else $error("vs active outside vertical blanking");

hpos_in_range: assert property (@(posedge clk) disable iff (rst) hpos < 8'(`H_TOTAL))
    else $error("hpos reached the line length");

// Sync stays low out of reset while the counters sit at the origin
sync_low_at_origin: assert property (@(posedge clk) (hpos == '0 && vpos == '0) |-> (!hs && !vs))
    else $error("sync active at raster origin");

endmodule

bind video_timing video_assertions u_timing_assert(
    .clk  ( clk  ),
    .rst  ( rst  ),
    .hpos ( hpos ),
    .vpos ( vpos ),
    .hbl  ( hbl  ),
    .vbl  ( vbl  ),
    .hs   ( hs   ),
    .vs   ( vs   )
);

// File: testbench/video_checker.sv
// Monitor that mirrors CPU writes and compares raster, read data and colour outputs
`include "video_macros.svh"

module video_checker(
    input                          clk,
    input                          rst,
    input                          pxl_cen,
    input  video_pkg::cpu_addr_t   cpu_addr,
    input                          cpu_wrn,
    input  video_pkg::cpu_data_t   cpu_dout,
    input                          cen_Q,
    input                          char_cs,
    input                          scr_cs,
    input                          pal_cs,
    input  video_pkg::cpu_data_t   char_dout,
    input  video_pkg::cpu_data_t   scr_dout,
    input  video_pkg::cpu_data_t   pal_dout,
    input  video_pkg::hpos_t       scrhpos,
    input  video_pkg::vpos_t       scrvpos,
    input                          hbl,
    input                          vbl,
    input                          hs,
    input                          vs,
    input                          ims,
    input                          lhbl_dly,
    input                          lvbl_dly,
    input  video_pkg::colour_t     red,
    input  video_pkg::colour_t     green,
    input  video_pkg::colour_t     blue,
    input                          check_en,   // Colour compare enable
    input  logic [127:0]           test_name,
    output int                     err_count,
    output int                     check_count
);
timeunit 1ns;
timeprecision 100ps;
import video_pkg::*;

cpu_data_t   cmap[0:63];
cpu_data_t   smap[0:63];
cpu_data_t   pal[0:63];
int          tick_n;          // Pixel ticks since reset
logic        tick_seen;
logic        rd_pend;
logic [1:0]  rd_sel;
cpu_data_t   rd_exp;
logic        hs_prev = 1'b0;
logic        vs_prev = 1'b0;
int          last_hs = -1;
int          last_vs = -1;

// Pattern rule of the ROM models where codes 00xxxxxx are empty char tiles
function automatic logic [3:0] gfx_nibble(bit layer, logic [7:0] code, logic [2:0] row,
                                          logic [2:0] col);
    logic [3:0] mix;
    if (!layer) begin
        if (code[7:6] == 2'b00) begin
            return 4'h0;
        end
        mix = code[3:0] ^ {row, 1'b0} ^ {1'b0, col};
    end else begin
        mix = code[3:0] + code[7:4] + {1'b0, row} + {col, 1'b0};
    end
    return mix;
endfunction

// {red, green, blue} for raster position (h, v)
function automatic logic [11:0] pixel_rgb(int h, int v);
    logic [7:0] sh;
    logic [7:0] sv;
    logic [3:0] cnib;
    logic [3:0] snib;
    logic [4:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    sh   = 8'(h) + scrhpos;
    sv   = 8'(v) + scrvpos;
    cnib = gfx_nibble(1'b0, cmap[{3'(v >> 3), 3'(h >> 3)}], 3'(v), 3'(h));
    snib = gfx_nibble(1'b1, smap[{sv[5:3], sh[5:3]}], sv[2:0], sh[2:0]);
    idx  = (cnib != 4'h0) ? {1'b0, cnib} : {1'b1, snib};    // Char over background
    lo   = pal[{idx, 1'b0}];
    hi   = pal[{idx, 1'b1}];
    return {lo[3:0], lo[7:4], hi[3:0]};
endfunction

task automatic check_val(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("ERROR %0s %0s: expected %0h, got %0h at tick %0d",
                 test_name, what, expected, actual, tick_n);
    end
endtask

task automatic check_tick();
    int  h;
    int  v;
    int  hd;
    int  vd;
    logic blank_d;
    h = tick_n % `H_TOTAL;
    v = (tick_n / `H_TOTAL) % `V_TOTAL;
    check_val("hbl", 32'(h >= `H_VISIBLE), 32'(hbl));
    check_val("vbl", 32'(v >= `V_VISIBLE), 32'(vbl));
    check_val("hs", 32'(h >= `HS_START && h < `HS_END), 32'(hs));
    check_val("vs", 32'(v >= `VS_START && v < `VS_END), 32'(vs));
    check_val("ims", 32'((v >> 3) & 1), 32'(ims));
    if (tick_n < 3) begin
        check_val("lhbl_dly", 32'd0, 32'(lhbl_dly));   // Pipeline still filling
        check_val("lvbl_dly", 32'd0, 32'(lvbl_dly));
        check_val("rgb blank", 32'd0, 32'({red, green, blue}));
    end else begin
        hd      = (tick_n - 3) % `H_TOTAL;
        vd      = ((tick_n - 3) / `H_TOTAL) % `V_TOTAL;
        blank_d = hd >= `H_VISIBLE || vd >= `V_VISIBLE;
        check_val("lhbl_dly", 32'(hd < `H_VISIBLE), 32'(lhbl_dly));
        check_val("lvbl_dly", 32'(vd < `V_VISIBLE), 32'(lvbl_dly));
        if (blank_d) begin
            check_val("rgb blank", 32'd0, 32'({red, green, blue}));
        end else if (check_en) begin
            check_val("rgb", 32'(pixel_rgb(hd, vd)), 32'({red, green, blue}));
        end
    end
    // Line and frame lengths from the sync edges
    if (hs && !hs_prev) begin
        if (last_hs >= 0) check_val("ticks per line", 32'(`H_TOTAL), 32'(tick_n - last_hs));
        last_hs = tick_n;
    end
    if (vs && !vs_prev) begin
        if (last_vs >= 0) begin
            check_val("ticks per frame", 32'(`H_TOTAL * `V_TOTAL), 32'(tick_n - last_vs));
        end
        last_vs = tick_n;
    end
    hs_prev = hs;
    vs_prev = vs;
endtask

always @(posedge clk) begin
    if (char_cs && !cpu_wrn && cen_Q) cmap[cpu_addr[5:0]] <= cpu_dout;
    if (scr_cs && !cpu_wrn && cen_Q)  smap[cpu_addr[5:0]] <= cpu_dout;
    if (pal_cs && !cpu_wrn && cen_Q)  pal[cpu_addr[5:0]]  <= cpu_dout;
    rd_pend <= (char_cs || scr_cs || pal_cs) && cpu_wrn;
    rd_sel  <= char_cs ? 2'd0 : (scr_cs ? 2'd1 : 2'd2);
    rd_exp  <= char_cs ? cmap[cpu_addr[5:0]] :
               (scr_cs ? smap[cpu_addr[5:0]] : pal[cpu_addr[5:0]]);
    if (rst) begin
        tick_n    <= 0;
        tick_seen <= 1'b0;
    end else begin
        tick_seen <= pxl_cen;
        if (pxl_cen) tick_n <= tick_n + 1;
    end
end

// Outputs are settled half a clock after the edge
always @(negedge clk) begin
    if (rd_pend) begin
        case (rd_sel)
            2'd0:    check_val("char_dout", 32'(rd_exp), 32'(char_dout));
            2'd1:    check_val("scr_dout", 32'(rd_exp), 32'(scr_dout));
            default: check_val("pal_dout", 32'(rd_exp), 32'(pal_dout));
        endcase
    end
    if (rst) begin
        hs_prev = 1'b0;
        vs_prev = 1'b0;
        last_hs = -1;
        last_vs = -1;
    end else if (tick_seen) begin
        check_tick();
    end
end

endmodule

// File: verilog/video_char.sv
// Module video_char: fixed character layer with CPU map port and pattern fetch
`include "video_macros.svh"

module video_char(
    input                          clk,
    input                          rst,
    input                          pxl_cen,
    // CPU bus
    input  video_pkg::cpu_addr_t   cpu_addr,
    input                          cpu_wrn,
    input  video_pkg::cpu_data_t   cpu_dout,
    input                          cen_Q,
    input                          char_cs,
    output video_pkg::cpu_data_t   char_dout,
    // Raster position
    input  video_pkg::hpos_t       hpos,
    input  video_pkg::vpos_t       vpos,
    // Pattern ROM
    output video_pkg::gfx_addr_t   rom_addr,
    input  video_pkg::gfx_row_t    rom_data,
    output video_pkg::layer_pxl_t  char_pxl
);
import video_pkg::*;

localparam int TW        = $clog2(`TILE_SIZE);
localparam int CW        = $clog2(`MAP_COLS);
localparam int RW        = $clog2(`MAP_ROWS);
localparam int MAP_DEPTH = `MAP_COLS * `MAP_ROWS;

tile_code_t          map_ram[0:MAP_DEPTH-1];
logic [RW+CW-1:0]    map_idx;
logic [TW-1:0]       pxl_col;     // Pixel column inside the tile
layer_pxl_t          pxl_nib;
logic                map_we;

assign map_we  = char_cs && !cpu_wrn && cen_Q;

// Tile row and column, upper bits drop out so the map wraps
assign map_idx = {vpos[TW+RW-1:TW], hpos[TW+CW-1:TW]};

// CPU side of the map
always_ff @(posedge clk) begin
    if (map_we) begin
        map_ram[cpu_addr[RW+CW-1:0]] <= cpu_dout;
    end
    if (char_cs) begin
        char_dout <= map_ram[cpu_addr[RW+CW-1:0]];
    end
end

// Tick 1 sends the address, the row comes back one clk later
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        rom_addr <= {map_ram[map_idx], vpos[TW-1:0]};
        pxl_col  <= hpos[TW-1:0];
    end
    pxl_nib <= rom_data[pxl_col*4 +: 4];  // Settled well before the next tick
end

// Tick 2 presents the pixel
always_ff @(posedge clk) begin
    if (rst) begin
        char_pxl <= '0;     // Transparent
    end else if (pxl_cen) begin
        char_pxl <= pxl_nib;
    end
end

endmodule

// File: verilog/video_colmix.sv
// Module video_colmix: layer priority, palette RAM, blanking delay and colour output
`include "video_macros.svh"

module video_colmix(
    input                          clk,
    input                          rst,
    input                          pxl_cen,
    // CPU bus
    input  video_pkg::cpu_addr_t   cpu_addr,
    input                          cpu_wrn,
    input  video_pkg::cpu_data_t   cpu_dout,
    input                          cen_Q,
    input                          pal_cs,
    output video_pkg::cpu_data_t   pal_dout,
    // Blanking
    input                          hbl,
    input                          vbl,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    // Layer pixels
    input  video_pkg::layer_pxl_t  char_pxl,
    input  video_pkg::layer_pxl_t  scr_pxl,
    // Colour output
    output video_pkg::colour_t     red,
    output video_pkg::colour_t     green,
    output video_pkg::colour_t     blue
);
import video_pkg::*;

localparam int PAL_BYTES = 2 * `PAL_ENTRIES;
localparam int PA        = $clog2(PAL_BYTES);

cpu_data_t   pal_ram[0:PAL_BYTES-1];    // Even byte {green, red}, odd byte blue
pal_idx_t    pal_idx;
logic        pal_we;
logic [1:0]  hbl_sr;                    // Blanking seen by the layer pipeline
logic [1:0]  vbl_sr;
logic        blank;

assign pal_we = pal_cs && !cpu_wrn && cen_Q;

// Opaque character pixel wins, background uses the upper half
assign pal_idx = char_pxl != '0 ? {1'b0, char_pxl} : {1'b1, scr_pxl};

// Blanking of the pixel now at the layer outputs
assign blank = hbl_sr[1] | vbl_sr[1];

always_ff @(posedge clk) begin
    if (pal_we) begin
        pal_ram[cpu_addr[PA-1:0]] <= cpu_dout;
    end
    if (pal_cs) begin
        pal_dout <= pal_ram[cpu_addr[PA-1:0]];
    end
end

// Three tick delay to match the colour registers
always_ff @(posedge clk) begin
    if (rst) begin
        hbl_sr   <= '1;     // Pipeline fill shows as blanked
        vbl_sr   <= '1;
        lhbl_dly <= 1'b0;
        lvbl_dly <= 1'b0;
    end else if (pxl_cen) begin
        hbl_sr   <= {hbl_sr[0], hbl};
        vbl_sr   <= {vbl_sr[0], vbl};
        lhbl_dly <= ~hbl_sr[1];
        lvbl_dly <= ~vbl_sr[1];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        red   <= '0;
        green <= '0;
        blue  <= '0;
    end else if (pxl_cen) begin
        if (blank) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            {green, red} <= pal_ram[{pal_idx, 1'b0}];
            blue         <= pal_ram[{pal_idx, 1'b1}][3:0];  // High nibble unused
        end
    end
end

endmodule

// File: verilog/video_macros.svh
// Screen geometry, sync windows, tile sizes and memory depths
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Horizontal raster, in pixels. Sync end is exclusive
`define H_TOTAL     64
`define H_VISIBLE   48
`define HS_START    52
`define HS_END      56

// Vertical raster, in lines
`define V_TOTAL     40
`define V_VISIBLE   32
`define VS_START    34
`define VS_END      36      // Exclusive, two lines of sync

`define MAP_COLS    8       // Map wraps every 64 pixels
`define MAP_ROWS    8
`define TILE_SIZE   8
`define PAL_ENTRIES 32      // 16 char colours, then 16 background colours

`endif

// File: verilog/video_pkg.sv
// Package video_pkg with the vector types shared by the video blocks
package video_pkg;

// Raster counters
typedef logic [7:0]  hpos_t;
typedef logic [7:0]  vpos_t;

// CPU bus
typedef logic [11:0] cpu_addr_t;
typedef logic [7:0]  cpu_data_t;

// Tile map entry, the pattern number
typedef logic [7:0]  tile_code_t;

// Layer colour index, 0 is transparent
typedef logic [3:0]  layer_pxl_t;

// Pattern ROM, {tile code, row in tile} gives one row of 8 nibbles
typedef logic [10:0] gfx_addr_t;
typedef logic [31:0] gfx_row_t;

// Palette lookup and output colour
typedef logic [4:0]  pal_idx_t;
typedef logic [3:0]  colour_t;

endpackage

// File: verilog/video_scroll.sv
// Module video_scroll: scrolling background layer with CPU map port and pattern fetch
`include "video_macros.svh"

module video_scroll(
    input                          clk,
    input                          rst,
    input                          pxl_cen,
    // CPU bus
    input  video_pkg::cpu_addr_t   cpu_addr,
    input                          cpu_wrn,
    input  video_pkg::cpu_data_t   cpu_dout,
    input                          cen_Q,
    input                          scr_cs,
    output video_pkg::cpu_data_t   scr_dout,
    // Raster position and scroll offsets
    input  video_pkg::hpos_t       hpos,
    input  video_pkg::vpos_t       vpos,
    input  video_pkg::hpos_t       scrhpos,
    input  video_pkg::vpos_t       scrvpos,
    // Pattern ROM
    output video_pkg::gfx_addr_t   rom_addr,
    input  video_pkg::gfx_row_t    rom_data,
    output video_pkg::layer_pxl_t  scr_pxl
);
import video_pkg::*;

localparam int TW        = $clog2(`TILE_SIZE);
localparam int CW        = $clog2(`MAP_COLS);
localparam int RW        = $clog2(`MAP_ROWS);
localparam int MAP_DEPTH = `MAP_COLS * `MAP_ROWS;

tile_code_t          map_ram[0:MAP_DEPTH-1];
hpos_t               scr_h;       // Position in background space
vpos_t               scr_v;
logic [RW+CW-1:0]    map_idx;
logic [TW-1:0]       pxl_col;
layer_pxl_t          pxl_nib;
logic                map_we;

assign map_we  = scr_cs && !cpu_wrn && cen_Q;
assign scr_h   = hpos + scrhpos;
assign scr_v   = vpos + scrvpos;
assign map_idx = {scr_v[TW+RW-1:TW], scr_h[TW+CW-1:TW]};

always_ff @(posedge clk) begin
    if (map_we) begin
        map_ram[cpu_addr[RW+CW-1:0]] <= cpu_dout;
    end
    if (scr_cs) begin
        scr_dout <= map_ram[cpu_addr[RW+CW-1:0]];
    end
end

// Same fetch timing as the character layer
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        rom_addr <= {map_ram[map_idx], scr_v[TW-1:0]};
        pxl_col  <= scr_h[TW-1:0];  // Fine scroll selects the nibble
    end
    pxl_nib <= rom_data[pxl_col*4 +: 4];
end

always_ff @(posedge clk) begin
    if (rst) begin
        scr_pxl <= '0;
    end else if (pxl_cen) begin
        scr_pxl <= pxl_nib;
    end
end

endmodule

// File: verilog/video_timing.sv
// Module video_timing: raster counters, blanking, sync and mid-screen interrupt
`include "video_macros.svh"

module video_timing(
    input                     clk,
    input                     rst,
    input                     pxl_cen,
    output video_pkg::hpos_t  hpos,
    output video_pkg::vpos_t  vpos,
    output logic              hbl,
    output logic              vbl,
    output logic              hs,
    output logic              vs,
    output                    ims       // Interrupt at mid screen
);
import video_pkg::*;

hpos_t  hpos_nxt;
vpos_t  vpos_nxt;
logic   h_wrap;
logic   v_wrap;

// Next counter values, decoded below so the windows line up with the counters
always_comb begin
    h_wrap   = hpos == hpos_t'(`H_TOTAL - 1);
    v_wrap   = vpos == vpos_t'(`V_TOTAL - 1);
    hpos_nxt = h_wrap ? '0 : hpos + 1'b1;
    if (h_wrap) begin
        vpos_nxt = v_wrap ? '0 : vpos + 1'b1;
    end else begin
        vpos_nxt = vpos;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        hpos <= '0;
        vpos <= '0;
        hbl  <= 1'b0;     // Counter at 0 is visible
        vbl  <= 1'b0;
        hs   <= 1'b0;
        vs   <= 1'b0;
    end else if (pxl_cen) begin
        hpos <= hpos_nxt;
        vpos <= vpos_nxt;
        hbl  <= hpos_nxt >= `H_VISIBLE;
        vbl  <= vpos_nxt >= `V_VISIBLE;
        hs   <= hpos_nxt >= `HS_START && hpos_nxt < `HS_END;
        vs   <= vpos_nxt >= `VS_START && vpos_nxt < `VS_END;
    end
end

// Toggles every 8 lines
assign ims = vpos[3];

endmodule

// File: verilog/video_top.sv
// Module video_top: timing generator, character and background layers and colour mixer
module video_top(
    input                          clk,
    input                          rst,
    input                          pxl_cen,
    // CPU bus
    input  video_pkg::cpu_addr_t   cpu_addr,
    input                          cpu_wrn,
    input  video_pkg::cpu_data_t   cpu_dout,
    input                          cen_Q,
    input                          char_cs,
    input                          scr_cs,
    input                          pal_cs,
    output video_pkg::cpu_data_t   char_dout,
    output video_pkg::cpu_data_t   scr_dout,
    output video_pkg::cpu_data_t   pal_dout,
    // Scroll registers
    input  video_pkg::hpos_t       scrhpos,
    input  video_pkg::vpos_t       scrvpos,
    // Graphics ROMs
    output video_pkg::gfx_addr_t   char_addr,
    input  video_pkg::gfx_row_t    char_data,
    output video_pkg::gfx_addr_t   scr_addr,
    input  video_pkg::gfx_row_t    scr_data,
    // Video
    output                         hbl,
    output                         vbl,
    output                         hs,
    output                         vs,
    output                         ims,
    output                         lhbl_dly,
    output                         lvbl_dly,
    output video_pkg::colour_t     red,
    output video_pkg::colour_t     green,
    output video_pkg::colour_t     blue
);
import video_pkg::*;

hpos_t       hpos;
vpos_t       vpos;
layer_pxl_t  char_pxl;   // Fixed text layer
layer_pxl_t  scr_pxl;    // Scrolling background

video_timing u_timing(
    .clk      ( clk       ),
    .rst      ( rst       ),
    .pxl_cen  ( pxl_cen   ),
    .hpos     ( hpos      ),
    .vpos     ( vpos      ),
    .hbl      ( hbl       ),
    .vbl      ( vbl       ),
    .hs       ( hs        ),
    .vs       ( vs        ),
    .ims      ( ims       )
);

video_char u_char(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .pxl_cen   ( pxl_cen    ),
    .cpu_addr  ( cpu_addr   ),
    .cpu_wrn   ( cpu_wrn    ),
    .cpu_dout  ( cpu_dout   ),
    .cen_Q     ( cen_Q      ),
    .char_cs   ( char_cs    ),
    .char_dout ( char_dout  ),
    .hpos      ( hpos       ),
    .vpos      ( vpos       ),
    .rom_addr  ( char_addr  ),
    .rom_data  ( char_data  ),
    .char_pxl  ( char_pxl   )
);

video_scroll u_scroll(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .pxl_cen   ( pxl_cen    ),
    .cpu_addr  ( cpu_addr   ),
    .cpu_wrn   ( cpu_wrn    ),
    .cpu_dout  ( cpu_dout   ),
    .cen_Q     ( cen_Q      ),
    .scr_cs    ( scr_cs     ),
    .scr_dout  ( scr_dout   ),
    .hpos      ( hpos       ),
    .vpos      ( vpos       ),
    .scrhpos   ( scrhpos    ),
    .scrvpos   ( scrvpos    ),
    .rom_addr  ( scr_addr   ),
    .rom_data  ( scr_data   ),
    .scr_pxl   ( scr_pxl    )
);

video_colmix u_colmix(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .pxl_cen   ( pxl_cen    ),
    .cpu_addr  ( cpu_addr   ),
    .cpu_wrn   ( cpu_wrn    ),
    .cpu_dout  ( cpu_dout   ),
    .cen_Q     ( cen_Q      ),
    .pal_cs    ( pal_cs     ),
    .pal_dout  ( pal_dout   ),
    .hbl       ( hbl        ),
    .vbl       ( vbl        ),
    .lhbl_dly  ( lhbl_dly   ),
    .lvbl_dly  ( lvbl_dly   ),
    .char_pxl  ( char_pxl   ),
    .scr_pxl   ( scr_pxl    ),
    .red       ( red        ),
    .green     ( green      ),
    .blue      ( blue       )
);

endmodule
